// File: hdl/regReadPkg.sv
`default_nettype none

package regReadPkg;

  // issue and write-back width of the core.
  localparam int NUM_LANES = 4;

  localparam int NUM_PHYS_REGS = 64;
  localparam int PHYS_TAG_W = 6;   // log2 of the physical file depth.
  localparam int DATA_W = 32;

  // in-flight branch checkpoints.
  localparam int NUM_CKPT = 4;
  localparam int CKPT_W = 2;

  // tags below this hold the committed state after reset.
  localparam int NUM_ARCH_REGS = 32;

  localparam int PAYLOAD_W = 8;    // stand-in for the instruction packet.

  typedef logic [PHYS_TAG_W-1:0] physTag_t;

  typedef logic [DATA_W-1:0] regData_t;

  typedef logic [NUM_CKPT-1:0] ckptMask_t;   // one bit per unresolved branch.

  typedef logic [CKPT_W-1:0] ckptId_t;

  typedef logic [NUM_PHYS_REGS-1:0] readyVec_t;

  typedef logic [PAYLOAD_W-1:0] payload_t;

endpackage

`default_nettype wire

// File: hdl/physRegFile.sv
`timescale 1ns/10ps
`default_nettype none

module physRegFile (
  input  wire                    clk,
  input  wire                    arstN_i,
  input  wire                    wrValid_i [regReadPkg::NUM_LANES],
  input  wire regReadPkg::physTag_t wrTag_i [regReadPkg::NUM_LANES],
  input  wire regReadPkg::regData_t wrData_i [regReadPkg::NUM_LANES],
  input  wire                    recover_i,
  input  wire regReadPkg::physTag_t rdTag_i [2*regReadPkg::NUM_LANES],
  output regReadPkg::regData_t   rdData_o [2*regReadPkg::NUM_LANES]
);

  import regReadPkg::*;

  regData_t regs [NUM_PHYS_REGS];
  logic     wrEn [NUM_LANES];

  // results of the wrong path never reach the file.
  for (genvar l = 0; l < NUM_LANES; l++) begin : gWrEn
    assign wrEn[l] = wrValid_i[l] & ~recover_i;
  end

  // lanes write distinct tags, so the loop order does not matter.
  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      for (int r = 0; r < NUM_PHYS_REGS; r++) begin
        regs[r] <= '0;
      end
    end else begin
      for (int l = 0; l < NUM_LANES; l++) begin
        if (wrEn[l]) begin
          regs[wrTag_i[l]] <= wrData_i[l];
        end
      end
    end
  end

  // two read ports per lane, src1 on even index.
  for (genvar p = 0; p < 2*NUM_LANES; p++) begin : gRead
    assign rdData_o[p] = regs[rdTag_i[p]];   // old contents until the edge.
  end

endmodule

`default_nettype wire

// File: hdl/regReadyTable.sv
`timescale 1ns/10ps
`default_nettype none

module regReadyTable (
  input  wire                    clk,
  input  wire                    arstN_i,
  input  wire                    unmapValid_i [regReadPkg::NUM_LANES],
  input  wire regReadPkg::physTag_t unmapTag_i [regReadPkg::NUM_LANES],
  input  wire                    wakeValid_i [regReadPkg::NUM_LANES],
  input  wire regReadPkg::physTag_t wakeTag_i [regReadPkg::NUM_LANES],
  output regReadPkg::readyVec_t  physRegReady_o
);

  import regReadPkg::*;

  readyVec_t ready;
  readyVec_t readyNext;

  // clears first, then sets, so a wakeup beats an unmap.
  always_comb begin
    readyNext = ready;
    for (int l = 0; l < NUM_LANES; l++) begin
      if (unmapValid_i[l]) begin
        readyNext[unmapTag_i[l]] = 1'b0;
      end
    end
    for (int l = 0; l < NUM_LANES; l++) begin
      if (wakeValid_i[l]) begin
        readyNext[wakeTag_i[l]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      for (int r = 0; r < NUM_PHYS_REGS; r++) begin
        ready[r] <= (r < NUM_ARCH_REGS);   // architectural map starts valid.
      end
    end else begin
      ready <= readyNext;
    end
  end

  assign physRegReady_o = ready;

endmodule

`default_nettype wire

// File: hdl/operandSelect.sv
`timescale 1ns/10ps
`default_nettype none

module operandSelect (
  input  wire                       clk,
  input  wire                       arstN_i,
  input  wire                       issueValid_i [regReadPkg::NUM_LANES],
  input  wire regReadPkg::physTag_t issueSrc1_i [regReadPkg::NUM_LANES],
  input  wire regReadPkg::physTag_t issueSrc2_i [regReadPkg::NUM_LANES],
  input  wire regReadPkg::ckptMask_t issueMask_i [regReadPkg::NUM_LANES],
  input  wire regReadPkg::payload_t issuePayload_i [regReadPkg::NUM_LANES],
  input  wire                       bypValid_i [regReadPkg::NUM_LANES],
  input  wire regReadPkg::physTag_t bypTag_i [regReadPkg::NUM_LANES],
  input  wire regReadPkg::regData_t bypData_i [regReadPkg::NUM_LANES],
  input  wire regReadPkg::regData_t fileData_i [2*regReadPkg::NUM_LANES],
  input  wire                       mispredict_i,
  input  wire regReadPkg::ckptId_t  mispredictCkpt_i,
  output regReadPkg::physTag_t      fileTag_o [2*regReadPkg::NUM_LANES],
  output logic                      opValid_o [regReadPkg::NUM_LANES],
  output regReadPkg::regData_t      opData1_o [regReadPkg::NUM_LANES],
  output regReadPkg::regData_t      opData2_o [regReadPkg::NUM_LANES],
  output regReadPkg::payload_t      opPayload_o [regReadPkg::NUM_LANES]
);

  import regReadPkg::*;

  logic [NUM_LANES-1:0] match1 [NUM_LANES];   // bit b set when bypass lane b hits.
  logic [NUM_LANES-1:0] match2 [NUM_LANES];
  regData_t             src1Data [NUM_LANES];
  regData_t             src2Data [NUM_LANES];
  logic                 issueLive [NUM_LANES];

  for (genvar l = 0; l < NUM_LANES; l++) begin : gLane
    assign fileTag_o[2*l]   = issueSrc1_i[l];
    assign fileTag_o[2*l+1] = issueSrc2_i[l];

    for (genvar b = 0; b < NUM_LANES; b++) begin : gMatch
      assign match1[l][b] = bypValid_i[b] && (bypTag_i[b] == issueSrc1_i[l]);
      assign match2[l][b] = bypValid_i[b] && (bypTag_i[b] == issueSrc2_i[l]);
    end

    // killed when it sits under the mispredicted branch.
    assign issueLive[l] = issueValid_i[l] &
                          ~(mispredict_i & issueMask_i[l][mispredictCkpt_i]);
  end

  // scan from the top so the lowest matching lane is the last to win.
  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      src1Data[l] = fileData_i[2*l];
      src2Data[l] = fileData_i[2*l+1];
      for (int b = NUM_LANES-1; b >= 0; b--) begin
        if (match1[l][b]) begin
          src1Data[l] = bypData_i[b];
        end
        if (match2[l][b]) begin
          src2Data[l] = bypData_i[b];
        end
      end
    end
  end

  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      for (int l = 0; l < NUM_LANES; l++) begin
        opValid_o[l] <= 1'b0;
      end
    end else begin
      for (int l = 0; l < NUM_LANES; l++) begin
        opValid_o[l] <= issueLive[l];
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int l = 0; l < NUM_LANES; l++) begin
      opData1_o[l]   <= src1Data[l];
      opData2_o[l]   <= src2Data[l];
      opPayload_o[l] <= issuePayload_i[l];   // carried along untouched.
    end
  end

endmodule

`default_nettype wire

// File: hdl/regRead.sv
`timescale 1ns/10ps
`default_nettype none

module regRead (
  input  wire                        clk,
  input  wire                        arstN_i,
  // issue lanes.
  input  wire                        issueValid_i [regReadPkg::NUM_LANES],
  input  wire regReadPkg::physTag_t  issueSrc1_i [regReadPkg::NUM_LANES],
  input  wire regReadPkg::physTag_t  issueSrc2_i [regReadPkg::NUM_LANES],
  input  wire regReadPkg::ckptMask_t issueMask_i [regReadPkg::NUM_LANES],
  input  wire regReadPkg::payload_t  issuePayload_i [regReadPkg::NUM_LANES],
  // write-back lanes, also the bypass sources.
  input  wire                        wrValid_i [regReadPkg::NUM_LANES],
  input  wire regReadPkg::physTag_t  wrTag_i [regReadPkg::NUM_LANES],
  input  wire regReadPkg::regData_t  wrData_i [regReadPkg::NUM_LANES],
  input  wire                        unmapValid_i [regReadPkg::NUM_LANES],
  input  wire regReadPkg::physTag_t  unmapTag_i [regReadPkg::NUM_LANES],
  input  wire                        wakeValid_i [regReadPkg::NUM_LANES],
  input  wire regReadPkg::physTag_t  wakeTag_i [regReadPkg::NUM_LANES],
  input  wire                        recover_i,
  input  wire                        mispredict_i,
  input  wire regReadPkg::ckptId_t   mispredictCkpt_i,
  output regReadPkg::readyVec_t      physRegReady_o,
  output logic                       opValid_o [regReadPkg::NUM_LANES],
  output regReadPkg::regData_t       opData1_o [regReadPkg::NUM_LANES],
  output regReadPkg::regData_t       opData2_o [regReadPkg::NUM_LANES],
  output regReadPkg::payload_t       opPayload_o [regReadPkg::NUM_LANES]
);

  import regReadPkg::*;

  physTag_t fileTag [2*NUM_LANES];    // src1/src2 pairs per lane.
  regData_t fileData [2*NUM_LANES];

  physRegFile u_physRegFile (
    .clk       (clk),
    .arstN_i   (arstN_i),
    .wrValid_i (wrValid_i),
    .wrTag_i   (wrTag_i),
    .wrData_i  (wrData_i),
    .recover_i (recover_i),
    .rdTag_i   (fileTag),
    .rdData_o  (fileData)
  );

  regReadyTable u_regReadyTable (
    .clk            (clk),
    .arstN_i        (arstN_i),
    .unmapValid_i   (unmapValid_i),
    .unmapTag_i     (unmapTag_i),
    .wakeValid_i    (wakeValid_i),
    .wakeTag_i      (wakeTag_i),
    .physRegReady_o (physRegReady_o)
  );

  // bypass sees write-backs even during recovery.
  operandSelect u_operandSelect (
    .clk              (clk),
    .arstN_i          (arstN_i),
    .issueValid_i     (issueValid_i),
    .issueSrc1_i      (issueSrc1_i),
    .issueSrc2_i      (issueSrc2_i),
    .issueMask_i      (issueMask_i),
    .issuePayload_i   (issuePayload_i),
    .bypValid_i       (wrValid_i),
    .bypTag_i         (wrTag_i),
    .bypData_i        (wrData_i),
    .fileData_i       (fileData),
    .mispredict_i     (mispredict_i),
    .mispredictCkpt_i (mispredictCkpt_i),
    .fileTag_o        (fileTag),
    .opValid_o        (opValid_o),
    .opData1_o        (opData1_o),
    .opData2_o        (opData2_o),
    .opPayload_o      (opPayload_o)
  );

endmodule

`default_nettype wire

// File: dv/regRead_sva.sv
`timescale 1ns/10ps
`default_nettype none

module regReadSva (
  input logic                  clk,
  input logic                  arstN_i,
  input logic                  issueValid_i [regReadPkg::NUM_LANES],
  input regReadPkg::ckptMask_t issueMask_i [regReadPkg::NUM_LANES],
  input logic                  mispredict_i,
  input regReadPkg::ckptId_t   mispredictCkpt_i,
  input logic                  opValid_o [regReadPkg::NUM_LANES],
  input regReadPkg::readyVec_t physRegReady_o
);

  import regReadPkg::*;

  int unsigned failCount = 0;   // failed assertion attempts.

  for (genvar l = 0; l < NUM_LANES; l++) begin : gLane
    validLowInReset: assert property (@(posedge clk) !arstN_i |-> !opValid_o[l])
      else begin
        failCount++;
        $error("opValid_o[%0d] high while reset is active", l);
      end

    // survivors of the squash come out one cycle later.
    issueGivesValid: assert property (@(posedge clk) disable iff (!arstN_i)
      (issueValid_i[l] && !(mispredict_i && issueMask_i[l][mispredictCkpt_i]))
      |=> opValid_o[l])
      else begin
        failCount++;
        $error("live issue on lane %0d gave no opValid_o", l);
      end
  end

  readyKnown: assert property (@(posedge clk) disable iff (!arstN_i)
    !$isunknown(physRegReady_o))
    else begin
      failCount++;
      $error("physRegReady_o holds unknown bits");
    end

endmodule

bind regRead regReadSva u_regReadSva (.*);

`default_nettype wire

// File: dv/regReadTb.sv
`timescale 1ns/10ps
`default_nettype none

module regReadTb;

  import regReadPkg::*;

  localparam int  MAX_CASES    = 64;
  localparam int  CASE_W       = 148;   // 37 hex digits per case line.
  localparam int  SETTLE_LIMIT = 20;
  localparam time RUN_LIMIT    = 100us;

  logic      clk;
  logic      arstN_i;
  logic      issueValid_i [NUM_LANES];
  physTag_t  issueSrc1_i [NUM_LANES];
  physTag_t  issueSrc2_i [NUM_LANES];
  ckptMask_t issueMask_i [NUM_LANES];
  payload_t  issuePayload_i [NUM_LANES];
  logic      wrValid_i [NUM_LANES];
  physTag_t  wrTag_i [NUM_LANES];
  regData_t  wrData_i [NUM_LANES];
  logic      unmapValid_i [NUM_LANES];
  physTag_t  unmapTag_i [NUM_LANES];
  logic      wakeValid_i [NUM_LANES];
  physTag_t  wakeTag_i [NUM_LANES];
  logic      recover_i;
  logic      mispredict_i;
  ckptId_t   mispredictCkpt_i;
  readyVec_t physRegReady_o;
  logic      opValid_o [NUM_LANES];
  regData_t  opData1_o [NUM_LANES];
  regData_t  opData2_o [NUM_LANES];
  payload_t  opPayload_o [NUM_LANES];

  logic [CASE_W-1:0] cases [MAX_CASES];
  payload_t          sentPayload [NUM_LANES];

  regRead u_regRead (.*);

  initial clk = 1'b0;
  always #5 clk = ~clk;

  initial begin
    #RUN_LIMIT;
    $display("simulation did not finish within its time limit");
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

  function automatic string testName(input logic [7:0] code);
    case (code)
      8'h01: return "reset";
      8'h02: return "writeRead";
      8'h03: return "bypass";
      8'h04: return "recover";
      8'h05: return "squash";
      8'h06: return "readyTable";
      default: return "unnamed";
    endcase
  endfunction

  // lane l sees the case mask turned left by l.
  function automatic ckptMask_t rotateMask(input ckptMask_t m, input int sh);
    return ckptMask_t'((m << sh) | (m >> (NUM_CKPT - sh)));
  endfunction

  task automatic stopRun(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic checkData(input string name, input regData_t expVal, input regData_t actVal);
    if (actVal !== expVal) begin
      stopRun($sformatf("[ERROR] %s: expected %h, actual %h", name, expVal, actVal));
    end
  endtask

  task automatic checkValid(input string name, input logic expVal, input logic actVal);
    if (actVal !== expVal) begin
      stopRun($sformatf("[ERROR] %s: expected %b, actual %b", name, expVal, actVal));
    end
  endtask

  task automatic checkReady(input string name, input readyVec_t expVal, input readyVec_t actVal);
    if (actVal !== expVal) begin
      stopRun($sformatf("[ERROR] %s: expected %h, actual %h", name, expVal, actVal));
    end
  endtask

  task automatic checkPayload(input string name, input payload_t expVal, input payload_t actVal);
    if (actVal !== expVal) begin
      stopRun($sformatf("[ERROR] %s: expected %h, actual %h", name, expVal, actVal));
    end
  endtask

  task automatic driveIdle();
    for (int l = 0; l < NUM_LANES; l++) begin
      issueValid_i[l]   = 1'b0;
      issueSrc1_i[l]    = '0;
      issueSrc2_i[l]    = '0;
      issueMask_i[l]    = '0;
      issuePayload_i[l] = payload_t'($urandom);
      wrValid_i[l]      = 1'b0;
      wrTag_i[l]        = '0;   // idle lanes alias tag 0 on purpose.
      wrData_i[l]       = regData_t'($urandom);
      unmapValid_i[l]   = 1'b0;
      unmapTag_i[l]     = '0;
      wakeValid_i[l]    = 1'b0;
      wakeTag_i[l]      = '0;
    end
    recover_i        = 1'b0;
    mispredict_i     = 1'b0;
    mispredictCkpt_i = '0;
  endtask

  task automatic applyCase(input logic [CASE_W-1:0] entry);
    logic [3:0]  kind;
    logic [3:0]  lane;
    logic [7:0]  flags;
    physTag_t    tag1;
    physTag_t    tag2;
    ckptMask_t   mask;
    logic [3:0]  expValid;
    regData_t    data;
    logic [63:0] expWord;
    string       name;
    int          ln;
    int          wl;
    name     = testName(entry[147:140]);
    kind     = entry[139:136];
    lane     = entry[135:132];
    flags    = entry[131:124];
    tag1     = entry[121:116];
    tag2     = entry[113:108];
    mask     = entry[107:104];
    expValid = entry[99:96];
    data     = entry[95:64];
    expWord  = entry[63:0];
    ln       = int'(lane[1:0]);
    wl       = (ln + 1) % NUM_LANES;
    @(posedge clk);
    #1;
    driveIdle();
    case (kind)
      4'h0: ;   // nothing driven, state check only.
      4'h1: begin
        wrValid_i[ln] = 1'b1;
        wrTag_i[ln]   = tag1;
        wrData_i[ln]  = data;
        recover_i     = flags[0];
      end
      4'h2: begin
        for (int l = 0; l < NUM_LANES; l++) begin
          if (lane[l]) begin
            issueValid_i[l] = 1'b1;
            issueSrc1_i[l]  = tag1;
            issueSrc2_i[l]  = tag2;
            issueMask_i[l]  = rotateMask(mask, l);
          end
        end
        recover_i        = flags[0];
        mispredict_i     = flags[1];
        mispredictCkpt_i = ckptId_t'(entry[101:100]);
        if (flags[2]) begin
          wrValid_i[flags[5:4]] = 1'b1;   // same-cycle write-back.
          wrTag_i[flags[5:4]]   = tag1;
          wrData_i[flags[5:4]]  = data;
        end
      end
      4'h5: begin
        unmapValid_i[ln] = 1'b1;
        unmapTag_i[ln]   = tag1;
      end
      4'h6: begin
        wakeValid_i[ln] = 1'b1;
        wakeTag_i[ln]   = tag1;
      end
      4'h7: begin
        unmapValid_i[ln] = 1'b1;
        unmapTag_i[ln]   = tag1;
        wakeValid_i[wl]  = 1'b1;
        wakeTag_i[wl]    = tag1;
      end
      default: stopRun($sformatf("case file holds an unknown operation kind %h", kind));
    endcase
    for (int l = 0; l < NUM_LANES; l++) begin
      sentPayload[l] = issuePayload_i[l];
    end
    @(posedge clk);
    #1;
    driveIdle();
    for (int l = 0; l < NUM_LANES; l++) begin
      checkValid($sformatf("%s lane%0d valid", name, l), expValid[l], opValid_o[l]);
      if (kind == 4'h2 && expValid[l]) begin
        checkData($sformatf("%s lane%0d data1", name, l), expWord[31:0], opData1_o[l]);
        checkData($sformatf("%s lane%0d data2", name, l), expWord[63:32], opData2_o[l]);
        checkPayload($sformatf("%s lane%0d payload", name, l), sentPayload[l], opPayload_o[l]);
      end
    end
    if (kind == 4'h0 || kind == 4'h5 || kind == 4'h6 || kind == 4'h7) begin
      checkReady($sformatf("%s ready", name), readyVec_t'(expWord), physRegReady_o);
    end
  endtask

  // the bound port checker counts its failed assertions.
  always @(posedge clk) begin
    if (u_regRead.u_regReadSva.failCount != 0) begin
      stopRun("an assertion on the DUT ports failed");
    end
  end

  initial begin
    int settle;
    int idx;
    void'($urandom(32'h3f55_9cb1));
    arstN_i = 1'b1;
    driveIdle();
    $readmemh("dv/regReadCases.mem", cases);
    #1;
    arstN_i = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    arstN_i = 1'b1;
    settle = 0;
    while ($isunknown(physRegReady_o) && settle < SETTLE_LIMIT) begin
      @(posedge clk);
      settle++;
    end
    if ($isunknown(physRegReady_o)) begin
      stopRun("ready table still holds unknown bits after reset was released");
    end
    idx = 0;
    while (idx < MAX_CASES && !$isunknown(cases[idx]) && cases[idx][139:136] != 4'hf) begin
      applyCase(cases[idx]);
      idx++;
    end
    if (idx == MAX_CASES || $isunknown(cases[idx])) begin
      stopRun("case file ended without its end marker");
    end else if (idx == 0) begin
      stopRun("case file holds no operations");
    end else if (u_regRead.u_regReadSva.failCount != 0) begin
      stopRun("an assertion on the DUT ports failed");
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: dv/regReadCases.mem
// name_kind_lane_flags_tag1_tag2_mask_ckpt_expValid_data_expect
// kind 0 check, 1 write, 2 issue, 5 unmap, 6 wake, 7 unmap+wake, f end
// flags bit0 recover, bit1 mispredict, bit2 bypass write, bits5:4 its lane
// expect is {data2, data1} for issues and the ready vector otherwise
01_0_0_00_00_00_0_0_0_00000000_00000000ffffffff
// plain write-back, then reads on both sources and all ports
02_1_0_00_10_00_0_0_0_11111111_0000000000000000
02_1_1_00_11_00_0_0_0_22222222_0000000000000000
02_1_3_00_3f_00_0_0_0_3f3f0001_0000000000000000
02_2_1_00_10_11_0_0_1_00000000_2222222211111111
02_2_f_00_11_3f_0_0_f_00000000_3f3f000122222222
02_2_4_00_3f_00_0_0_4_00000000_000000003f3f0001
02_1_2_00_10_00_0_0_0_a5a5a5a5_0000000000000000
02_2_8_00_00_10_0_0_8_00000000_a5a5a5a500000000
// same-cycle forwarding beats the file
03_2_1_04_20_21_0_0_1_cafe0020_00000000cafe0020
03_2_6_34_21_20_0_0_6_0badf00d_cafe00200badf00d
03_1_0_00_22_00_0_0_0_12345678_0000000000000000
03_2_1_14_22_22_0_0_1_87654321_8765432187654321
03_2_1_00_22_21_0_0_1_00000000_0badf00d87654321
// writes during recovery forward but never land
04_1_0_00_30_00_0_0_0_aaaa0030_0000000000000000
04_2_1_25_30_30_0_0_1_5555beef_5555beef5555beef
04_2_1_00_30_20_0_0_1_00000000_cafe0020aaaa0030
04_1_3_01_31_00_0_0_0_deadbeef_0000000000000000
04_2_2_00_31_30_0_0_2_00000000_aaaa003000000000
// lane masks are the mask column turned left by the lane number
05_2_f_02_10_20_1_2_b_00000000_cafe0020a5a5a5a5
05_2_f_02_10_20_3_0_6_00000000_cafe0020a5a5a5a5
05_2_f_00_10_20_f_1_f_00000000_cafe0020a5a5a5a5
05_2_5_02_10_20_0_3_5_00000000_cafe0020a5a5a5a5
// ready table updates, wakeup wins over unmap
06_5_0_00_05_00_0_0_0_00000000_00000000ffffffdf
06_6_1_00_28_00_0_0_0_00000000_00000100ffffffdf
06_6_3_00_05_00_0_0_0_00000000_00000100ffffffff
06_7_2_00_30_00_0_0_0_00000000_00010100ffffffff
06_7_3_00_05_00_0_0_0_00000000_00010100ffffffff
06_5_2_00_28_00_0_0_0_00000000_00010000ffffffff
06_5_1_00_00_00_0_0_0_00000000_00010000fffffffe
06_6_0_00_3f_00_0_0_0_00000000_80010000fffffffe
00_f_0_00_00_00_0_0_0_00000000_0000000000000000

// File: filelist.f
hdl/regReadPkg.sv
hdl/physRegFile.sv
hdl/regReadyTable.sv
hdl/operandSelect.sv
hdl/regRead.sv
dv/regRead_sva.sv
dv/regReadTb.sv

// File: Bender.yml
package:
  name: regRead

sources:
  - files:
      - hdl/regReadPkg.sv
      - hdl/physRegFile.sv
      - hdl/regReadyTable.sv
      - hdl/operandSelect.sv
      - hdl/regRead.sv
  - target: test
    files:
      - dv/regRead_sva.sv
      - dv/regReadTb.sv
